// ==== Makefile ====
# Verilator build and run for the mesh row testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -j 0 --top-module mesh_row_tb \
		-Mdir obj_dir -f project.f

run: compile
	./obj_dir/Vmesh_row_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q '\*\* PASS \*\*' sim.log; then \
		echo "simulation ended without passing"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== project.f ====
src/mesh_pkg.sv
src/host_injector.sv
src/mesh_router_node.sv
src/tile_dmem.sv
src/mesh_tile.sv
src/response_collector.sv
src/mesh_row_top.sv
tb/mesh_row_assert.sv
tb/mesh_row_tb.sv

// ==== src/host_injector.sv ====
// one command per cycle max, no back-pressure; x >= num_tiles_p is dropped with a cmd_err_o pulse
`default_nettype none

module host_injector #(
  parameter int num_tiles_p  = mesh_pkg::DEF_NUM_TILES,
  parameter int x_width_p    = mesh_pkg::DEF_X_WIDTH,
  parameter int addr_width_p = mesh_pkg::DEF_ADDR_WIDTH,
  parameter int data_width_p = mesh_pkg::DEF_DATA_WIDTH,
  parameter int tag_width_p  = mesh_pkg::DEF_TAG_WIDTH
) (
  input  wire                       clk_i,
  input  wire                       arst_n_i,
  input  wire                       cmd_v_i,
  input  wire mesh_pkg::op_e        cmd_op_i,
  input  wire [x_width_p-1:0]       cmd_x_i,
  input  wire [addr_width_p-1:0]    cmd_addr_i,
  input  wire [data_width_p-1:0]    cmd_data_i,
  input  wire [tag_width_p-1:0]     cmd_tag_i,
  output logic                      cmd_err_o,
  output logic                      flit_v_o,
  output mesh_pkg::pkt_kind_e       flit_kind_o,
  output mesh_pkg::op_e             flit_op_o,
  output logic [x_width_p-1:0]      flit_x_o,
  output logic [addr_width_p-1:0]   flit_addr_o,
  output logic [data_width_p-1:0]   flit_data_o,
  output logic [tag_width_p-1:0]    flit_tag_o
);
  import mesh_pkg::*;

  // one extra bit so a tile count of 2**x_width_p still compares correctly
  localparam logic [x_width_p:0] num_tiles_lp = (x_width_p + 1)'(num_tiles_p);

  logic cmd_legal;

  assign cmd_legal = ({1'b0, cmd_x_i} < num_tiles_lp);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      flit_v_o  <= 1'b0;
      cmd_err_o <= 1'b0;
    end else begin
      flit_v_o  <= cmd_v_i & cmd_legal;
      cmd_err_o <= cmd_v_i & ~cmd_legal;
    end
  end

  // request payload, captured with each command
  always_ff @(posedge clk_i) begin
    if (cmd_v_i) begin
      flit_kind_o <= PKT_REQ;
      flit_op_o   <= cmd_op_i;
      flit_x_o    <= cmd_x_i;
      flit_addr_o <= cmd_addr_i;
      flit_data_o <= cmd_data_i;
      flit_tag_o  <= cmd_tag_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/mesh_pkg.sv ====
// shared flit/opcode encodings and default sizes; x width must hold every tile index
`default_nettype none

package mesh_pkg;

  // flit kind on the row links
  typedef enum logic {
    PKT_REQ = 1'b0,
    PKT_RSP = 1'b1
  } pkt_kind_e;

  // host memory command opcodes, 2'b11 is unused
  typedef enum logic [1:0] {
    OP_STORE = 2'd0,
    OP_LOAD  = 2'd1,
    OP_ADD   = 2'd2
  } op_e;

  // default row geometry
  localparam int DEF_NUM_TILES = 4;
  localparam int DEF_X_WIDTH   = 3;

  // default payload sizes, 16 words per tile
  localparam int DEF_ADDR_WIDTH = 4;
  localparam int DEF_DATA_WIDTH = 32;
  localparam int DEF_TAG_WIDTH  = 8;

endpackage

`default_nettype wire

// ==== src/mesh_router_node.sv ====
// eastbound-only link stage; a delivered request leaves as a response in the same slot
`default_nettype none

module mesh_router_node #(
  parameter int x_width_p    = mesh_pkg::DEF_X_WIDTH,
  parameter int addr_width_p = mesh_pkg::DEF_ADDR_WIDTH,
  parameter int data_width_p = mesh_pkg::DEF_DATA_WIDTH,
  parameter int tag_width_p  = mesh_pkg::DEF_TAG_WIDTH,
  parameter int tile_x_p     = 0
) (
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  // west link
  input  wire                       in_v_i,
  input  wire mesh_pkg::pkt_kind_e  in_kind_i,
  input  wire mesh_pkg::op_e        in_op_i,
  input  wire [x_width_p-1:0]       in_x_i,
  input  wire [addr_width_p-1:0]    in_addr_i,
  input  wire [data_width_p-1:0]    in_data_i,
  input  wire [tag_width_p-1:0]     in_tag_i,
  // east link
  output logic                      out_v_o,
  output mesh_pkg::pkt_kind_e       out_kind_o,
  output mesh_pkg::op_e             out_op_o,
  output logic [x_width_p-1:0]      out_x_o,
  output logic [addr_width_p-1:0]   out_addr_o,
  output logic [data_width_p-1:0]   out_data_o,
  output logic [tag_width_p-1:0]    out_tag_o,
  // local data memory
  output logic                      mem_en_o,
  output mesh_pkg::op_e             mem_op_o,
  output logic [addr_width_p-1:0]   mem_addr_o,
  output logic [data_width_p-1:0]   mem_data_o,
  input  wire [data_width_p-1:0]    mem_result_i
);
  import mesh_pkg::*;

  localparam logic [x_width_p-1:0] my_x_lp = x_width_p'(tile_x_p);

  logic hit;

  // only a request for this column is consumed here
  assign hit = in_v_i && (in_kind_i == PKT_REQ) && (in_x_i == my_x_lp);

  assign mem_en_o   = hit;
  assign mem_op_o   = in_op_i;
  assign mem_addr_o = in_addr_i;
  assign mem_data_o = in_data_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_v_o <= 1'b0;
    end else begin
      out_v_o <= in_v_i;
    end
  end

  // turn a hit into a response, pass everything else on untouched
  always_ff @(posedge clk_i) begin
    if (in_v_i) begin
      out_kind_o <= hit ? PKT_RSP : in_kind_i;
      out_data_o <= hit ? mem_result_i : in_data_i;
      out_op_o   <= in_op_i;
      out_x_o    <= in_x_i;
      out_addr_o <= in_addr_i;
      out_tag_o  <= in_tag_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/mesh_row_top.sv ====
// one-row mesh; legal command at edge k answers at edge k+num_tiles_p+2, num_tiles_p <= 2**x_width_p
`default_nettype none

module mesh_row_top #(
  parameter int num_tiles_p  = mesh_pkg::DEF_NUM_TILES,
  parameter int x_width_p    = mesh_pkg::DEF_X_WIDTH,
  parameter int addr_width_p = mesh_pkg::DEF_ADDR_WIDTH,
  parameter int data_width_p = mesh_pkg::DEF_DATA_WIDTH,
  parameter int tag_width_p  = mesh_pkg::DEF_TAG_WIDTH
) (
  input  wire                       clk_i,
  input  wire                       arst_n_i,
  input  wire                       cmd_v_i,
  input  wire mesh_pkg::op_e        cmd_op_i,
  input  wire [x_width_p-1:0]       cmd_x_i,
  input  wire [addr_width_p-1:0]    cmd_addr_i,
  input  wire [data_width_p-1:0]    cmd_data_i,
  input  wire [tag_width_p-1:0]     cmd_tag_i,
  output logic                      cmd_err_o,
  output logic                      rsp_v_o,
  output mesh_pkg::op_e             rsp_op_o,
  output logic [tag_width_p-1:0]    rsp_tag_o,
  output logic [data_width_p-1:0]   rsp_data_o,
  output logic [15:0]               rsp_count_o
);
  import mesh_pkg::*;

  // link i feeds tile i, link num_tiles_p feeds the collector
  logic                    link_v    [num_tiles_p+1];
  pkt_kind_e               link_kind [num_tiles_p+1];
  op_e                     link_op   [num_tiles_p+1];
  logic [x_width_p-1:0]    link_x    [num_tiles_p+1];
  logic [addr_width_p-1:0] link_addr [num_tiles_p+1];
  logic [data_width_p-1:0] link_data [num_tiles_p+1];
  logic [tag_width_p-1:0]  link_tag  [num_tiles_p+1];

  host_injector #(
    .num_tiles_p (num_tiles_p),
    .x_width_p   (x_width_p),
    .addr_width_p(addr_width_p),
    .data_width_p(data_width_p),
    .tag_width_p (tag_width_p)
  ) host_injector_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .cmd_v_i    (cmd_v_i),
    .cmd_op_i   (cmd_op_i),
    .cmd_x_i    (cmd_x_i),
    .cmd_addr_i (cmd_addr_i),
    .cmd_data_i (cmd_data_i),
    .cmd_tag_i  (cmd_tag_i),
    .cmd_err_o  (cmd_err_o),
    .flit_v_o   (link_v[0]),
    .flit_kind_o(link_kind[0]),
    .flit_op_o  (link_op[0]),
    .flit_x_o   (link_x[0]),
    .flit_addr_o(link_addr[0]),
    .flit_data_o(link_data[0]),
    .flit_tag_o (link_tag[0])
  );

  for (genvar i = 0; i < num_tiles_p; i++) begin : g_tile
    mesh_tile #(
      .x_width_p   (x_width_p),
      .addr_width_p(addr_width_p),
      .data_width_p(data_width_p),
      .tag_width_p (tag_width_p),
      .tile_x_p    (i)
    ) mesh_tile_inst (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .in_v_i    (link_v[i]),
      .in_kind_i (link_kind[i]),
      .in_op_i   (link_op[i]),
      .in_x_i    (link_x[i]),
      .in_addr_i (link_addr[i]),
      .in_data_i (link_data[i]),
      .in_tag_i  (link_tag[i]),
      .out_v_o   (link_v[i+1]),
      .out_kind_o(link_kind[i+1]),
      .out_op_o  (link_op[i+1]),
      .out_x_o   (link_x[i+1]),
      .out_addr_o(link_addr[i+1]),
      .out_data_o(link_data[i+1]),
      .out_tag_o (link_tag[i+1])
    );
  end

  response_collector #(
    .data_width_p(data_width_p),
    .tag_width_p (tag_width_p)
  ) response_collector_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .in_v_i     (link_v[num_tiles_p]),
    .in_kind_i  (link_kind[num_tiles_p]),
    .in_op_i    (link_op[num_tiles_p]),
    .in_data_i  (link_data[num_tiles_p]),
    .in_tag_i   (link_tag[num_tiles_p]),
    .rsp_v_o    (rsp_v_o),
    .rsp_op_o   (rsp_op_o),
    .rsp_tag_o  (rsp_tag_o),
    .rsp_data_o (rsp_data_o),
    .rsp_count_o(rsp_count_o)
  );

endmodule

`default_nettype wire

// ==== src/mesh_tile.sv ====
// one row tile; local reset leaves two clocks after arst_n_i rises, flits sent earlier are lost
`default_nettype none

module mesh_tile #(
  parameter int x_width_p    = mesh_pkg::DEF_X_WIDTH,
  parameter int addr_width_p = mesh_pkg::DEF_ADDR_WIDTH,
  parameter int data_width_p = mesh_pkg::DEF_DATA_WIDTH,
  parameter int tag_width_p  = mesh_pkg::DEF_TAG_WIDTH,
  parameter int tile_x_p     = 0
) (
  input  wire                       clk_i,
  input  wire                       arst_n_i,
  input  wire                       in_v_i,
  input  wire mesh_pkg::pkt_kind_e  in_kind_i,
  input  wire mesh_pkg::op_e        in_op_i,
  input  wire [x_width_p-1:0]       in_x_i,
  input  wire [addr_width_p-1:0]    in_addr_i,
  input  wire [data_width_p-1:0]    in_data_i,
  input  wire [tag_width_p-1:0]     in_tag_i,
  output logic                      out_v_o,
  output mesh_pkg::pkt_kind_e       out_kind_o,
  output mesh_pkg::op_e             out_op_o,
  output logic [x_width_p-1:0]      out_x_o,
  output logic [addr_width_p-1:0]   out_addr_o,
  output logic [data_width_p-1:0]   out_data_o,
  output logic [tag_width_p-1:0]    out_tag_o
);
  import mesh_pkg::*;

  logic [1:0]              rst_sync_r;
  logic                    rst_n;
  logic                    mem_en;
  op_e                     mem_op;
  logic [addr_width_p-1:0] mem_addr;
  logic [data_width_p-1:0] mem_data;
  logic [data_width_p-1:0] mem_result;

  // reset re-timed per tile, async assert, sync release
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_sync_r <= 2'b00;
    end else begin
      rst_sync_r <= {rst_sync_r[0], 1'b1};
    end
  end

  assign rst_n = rst_sync_r[1];

  mesh_router_node #(
    .x_width_p   (x_width_p),
    .addr_width_p(addr_width_p),
    .data_width_p(data_width_p),
    .tag_width_p (tag_width_p),
    .tile_x_p    (tile_x_p)
  ) mesh_router_node_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n),
    .in_v_i      (in_v_i),
    .in_kind_i   (in_kind_i),
    .in_op_i     (in_op_i),
    .in_x_i      (in_x_i),
    .in_addr_i   (in_addr_i),
    .in_data_i   (in_data_i),
    .in_tag_i    (in_tag_i),
    .out_v_o     (out_v_o),
    .out_kind_o  (out_kind_o),
    .out_op_o    (out_op_o),
    .out_x_o     (out_x_o),
    .out_addr_o  (out_addr_o),
    .out_data_o  (out_data_o),
    .out_tag_o   (out_tag_o),
    .mem_en_o    (mem_en),
    .mem_op_o    (mem_op),
    .mem_addr_o  (mem_addr),
    .mem_data_o  (mem_data),
    .mem_result_i(mem_result)
  );

  tile_dmem #(
    .addr_width_p(addr_width_p),
    .data_width_p(data_width_p)
  ) tile_dmem_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n),
    .mem_en_i    (mem_en),
    .mem_op_i    (mem_op),
    .mem_addr_i  (mem_addr),
    .mem_data_i  (mem_data),
    .mem_result_o(mem_result)
  );

endmodule

`default_nettype wire

// ==== src/response_collector.sv ====
// drains the east edge every cycle; request flits that reach it are ignored, count wraps at 16 bits
`default_nettype none

module response_collector #(
  parameter int data_width_p = mesh_pkg::DEF_DATA_WIDTH,
  parameter int tag_width_p  = mesh_pkg::DEF_TAG_WIDTH
) (
  input  wire                       clk_i,
  input  wire                       arst_n_i,
  input  wire                       in_v_i,
  input  wire mesh_pkg::pkt_kind_e  in_kind_i,
  input  wire mesh_pkg::op_e        in_op_i,
  input  wire [data_width_p-1:0]    in_data_i,
  input  wire [tag_width_p-1:0]     in_tag_i,
  output logic                      rsp_v_o,
  output mesh_pkg::op_e             rsp_op_o,
  output logic [tag_width_p-1:0]    rsp_tag_o,
  output logic [data_width_p-1:0]   rsp_data_o,
  output logic [15:0]               rsp_count_o
);
  import mesh_pkg::*;

  logic rsp_hit;

  assign rsp_hit = in_v_i && (in_kind_i == PKT_RSP);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_v_o     <= 1'b0;
      rsp_count_o <= '0;
    end else begin
      rsp_v_o <= rsp_hit;
      if (rsp_hit) begin
        rsp_count_o <= rsp_count_o + 16'd1;
      end
    end
  end

  // host response payload
  always_ff @(posedge clk_i) begin
    if (rsp_hit) begin
      rsp_op_o   <= in_op_i;
      rsp_tag_o  <= in_tag_i;
      rsp_data_o <= in_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/tile_dmem.sv ====
// 2**addr_width_p words cleared by reset; combinational read, write on the edge when enabled
`default_nettype none

module tile_dmem #(
  parameter int addr_width_p = mesh_pkg::DEF_ADDR_WIDTH,
  parameter int data_width_p = mesh_pkg::DEF_DATA_WIDTH
) (
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  input  wire                       mem_en_i,
  input  wire mesh_pkg::op_e        mem_op_i,
  input  wire [addr_width_p-1:0]    mem_addr_i,
  input  wire [data_width_p-1:0]    mem_data_i,
  output logic [data_width_p-1:0]   mem_result_o
);
  import mesh_pkg::*;

  localparam int words_lp = 2 ** addr_width_p;

  logic [data_width_p-1:0] mem_r [words_lp];
  logic [data_width_p-1:0] rd_data;
  logic [data_width_p-1:0] wr_data;
  logic                    wr_en;

  assign rd_data = mem_r[mem_addr_i];

  // execute unit
  always_comb begin
    wr_en        = 1'b0;
    wr_data      = rd_data;
    mem_result_o = rd_data;
    case (mem_op_i)
      OP_STORE: begin
        wr_en        = mem_en_i;
        wr_data      = mem_data_i;
        mem_result_o = mem_data_i;
      end
      OP_ADD: begin
        // old value goes back, sum stays in memory
        wr_en   = mem_en_i;
        wr_data = rd_data + mem_data_i;
      end
      default: begin
        wr_en = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < words_lp; i++) begin
        mem_r[i] <= '0;
      end
    end else if (wr_en) begin
      mem_r[mem_addr_i] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== tb/mesh_row_assert.sv ====
// bound into mesh_row_top; timing rules assume tiles left reset before the first command
`default_nettype none

module mesh_row_assert #(
  parameter int num_tiles_p = mesh_pkg::DEF_NUM_TILES,
  parameter int x_width_p   = mesh_pkg::DEF_X_WIDTH
) (
  input wire                 clk_i,
  input wire                 arst_n_i,
  input wire                 cmd_v_i,
  input wire [x_width_p-1:0] cmd_x_i,
  input wire                 cmd_err_o,
  input wire                 rsp_v_o,
  input wire [15:0]          rsp_count_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int   fail_count = 0;
  logic legal_cmd;
  logic illegal_cmd;

  assign legal_cmd   = cmd_v_i && (int'(cmd_x_i) < num_tiles_p);
  assign illegal_cmd = cmd_v_i && (int'(cmd_x_i) >= num_tiles_p);

  // host outputs stay quiet while reset is held
  quiet_in_reset: assert property (@(posedge clk_i)
    !arst_n_i |-> (!rsp_v_o && !cmd_err_o && rsp_count_o == 16'd0))
    else begin
      fail_count++;
      $error("host outputs active during reset");
    end

  // fixed pipeline latency through the row
  rsp_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    legal_cmd |-> ##(num_tiles_p + 2) rsp_v_o)
    else begin
      fail_count++;
      $error("no response num_tiles_p+2 cycles after a legal command");
    end

  // every response traces back to a legal command
  rsp_has_cmd: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_v_o |-> $past(legal_cmd, num_tiles_p + 2))
    else begin
      fail_count++;
      $error("response without a matching legal command");
    end

  illegal_no_rsp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    illegal_cmd |-> ##(num_tiles_p + 2) !rsp_v_o)
    else begin
      fail_count++;
      $error("response after a dropped command");
    end

  err_follows_cmd: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    illegal_cmd |=> cmd_err_o)
    else begin
      fail_count++;
      $error("cmd_err_o missing after an out-of-range command");
    end

  // one pulse per bad command, never on its own
  err_single_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_err_o |-> $past(illegal_cmd))
    else begin
      fail_count++;
      $error("cmd_err_o high without an out-of-range command");
    end

endmodule

bind mesh_row_top mesh_row_assert #(
  .num_tiles_p(num_tiles_p),
  .x_width_p  (x_width_p)
) mesh_row_assert_inst (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .cmd_v_i    (cmd_v_i),
  .cmd_x_i    (cmd_x_i),
  .cmd_err_o  (cmd_err_o),
  .rsp_v_o    (rsp_v_o),
  .rsp_count_o(rsp_count_o)
);

`default_nettype wire

// ==== tb/mesh_row_tb.sv ====
// default parameters only; commands start after the per-tile reset synchronizers release
`default_nettype none

module mesh_row_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import mesh_pkg::*;

  localparam int num_tiles_lp = DEF_NUM_TILES;
  localparam int words_lp     = 2 ** DEF_ADDR_WIDTH;
  localparam int latency_lp   = num_tiles_lp + 2;

  logic                      clk_i = 1'b0;
  logic                      arst_n_i;
  logic                      cmd_v_i;
  op_e                       cmd_op_i;
  logic [DEF_X_WIDTH-1:0]    cmd_x_i;
  logic [DEF_ADDR_WIDTH-1:0] cmd_addr_i;
  logic [DEF_DATA_WIDTH-1:0] cmd_data_i;
  logic [DEF_TAG_WIDTH-1:0]  cmd_tag_i;
  logic                      cmd_err_o;
  logic                      rsp_v_o;
  op_e                       rsp_op_o;
  logic [DEF_TAG_WIDTH-1:0]  rsp_tag_o;
  logic [DEF_DATA_WIDTH-1:0] rsp_data_o;
  logic [15:0]               rsp_count_o;

  logic [31:0]               lfsr_state = 32'h0359_eedc;
  logic [DEF_DATA_WIDTH-1:0] ref_mem [num_tiles_lp][words_lp];
  logic [DEF_TAG_WIDTH-1:0]  next_tag = '0;
  int                        cycle_cnt = 0;
  int                        legal_cnt = 0;
  logic [DEF_TAG_WIDTH-1:0]  exp_tag_q  [$];
  logic [DEF_DATA_WIDTH-1:0] exp_data_q [$];
  op_e                       exp_op_q   [$];
  int                        exp_cyc_q  [$];

  mesh_row_top mesh_row_top_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .cmd_v_i    (cmd_v_i),
    .cmd_op_i   (cmd_op_i),
    .cmd_x_i    (cmd_x_i),
    .cmd_addr_i (cmd_addr_i),
    .cmd_data_i (cmd_data_i),
    .cmd_tag_i  (cmd_tag_i),
    .cmd_err_o  (cmd_err_o),
    .rsp_v_o    (rsp_v_o),
    .rsp_op_o   (rsp_op_o),
    .rsp_tag_o  (rsp_tag_o),
    .rsp_data_o (rsp_data_o),
    .rsp_count_o(rsp_count_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at first error");
  endtask

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // drives one command for one cycle and records what the host should see
  task automatic send_cmd(input op_e op, input int x, input int addr,
                          input logic [DEF_DATA_WIDTH-1:0] data);
    logic [DEF_DATA_WIDTH-1:0] old_val;
    @(posedge clk_i);
    cmd_v_i    <= 1'b1;
    cmd_op_i   <= op;
    cmd_x_i    <= DEF_X_WIDTH'(x);
    cmd_addr_i <= DEF_ADDR_WIDTH'(addr);
    cmd_data_i <= data;
    cmd_tag_i  <= next_tag;
    if (x < num_tiles_lp) begin
      old_val = ref_mem[x][addr];
      exp_tag_q.push_back(next_tag);
      exp_op_q.push_back(op);
      // cycle_cnt has not counted this edge yet
      exp_cyc_q.push_back(cycle_cnt + 1 + latency_lp);
      case (op)
        OP_STORE: begin
          ref_mem[x][addr] = data;
          exp_data_q.push_back(data);
        end
        OP_ADD: begin
          ref_mem[x][addr] = old_val + data;
          exp_data_q.push_back(old_val);
        end
        default: begin
          exp_data_q.push_back(old_val);
        end
      endcase
      legal_cnt++;
    end
    next_tag = next_tag + 1'b1;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      cmd_v_i <= 1'b0;
    end
  endtask

  task automatic drain();
    int waited;
    idle(1);
    waited = 0;
    while (exp_tag_q.size() != 0) begin
      @(posedge clk_i);
      waited++;
      if (waited > 50) begin
        report_failure("timeout waiting for outstanding responses");
      end
    end
  endtask

  // responses compared mid-cycle where outputs are stable
  always @(negedge clk_i) begin
    if (mesh_row_top_inst.mesh_row_assert_inst.fail_count != 0) begin
      report_failure("concurrent assertion failed");
    end
    if (rsp_v_o) begin
      if (exp_tag_q.size() == 0) begin
        report_failure("response arrived with no command outstanding");
      end
      if (rsp_tag_o !== exp_tag_q[0]) begin
        report_failure($sformatf("Mismatch rsp_tag_o: got %h expected %h",
                                 rsp_tag_o, exp_tag_q[0]));
      end
      if (rsp_op_o !== exp_op_q[0]) begin
        report_failure($sformatf("Mismatch rsp_op_o: got %h expected %h",
                                 rsp_op_o, exp_op_q[0]));
      end
      if (rsp_data_o !== exp_data_q[0]) begin
        report_failure($sformatf("Mismatch rsp_data_o: got %h expected %h",
                                 rsp_data_o, exp_data_q[0]));
      end
      if (cycle_cnt != exp_cyc_q[0]) begin
        report_failure($sformatf("response for tag %h came at cycle %0d instead of %0d",
                                 rsp_tag_o, cycle_cnt, exp_cyc_q[0]));
      end
      void'(exp_tag_q.pop_front());
      void'(exp_op_q.pop_front());
      void'(exp_data_q.pop_front());
      void'(exp_cyc_q.pop_front());
    end
  end

  initial begin
    int r_op;
    arst_n_i   = 1'b0;
    cmd_v_i    = 1'b0;
    cmd_op_i   = OP_LOAD;
    cmd_x_i    = '0;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    cmd_tag_i  = '0;
    for (int t = 0; t < num_tiles_lp; t++) begin
      for (int a = 0; a < words_lp; a++) begin
        ref_mem[t][a] = '0;
      end
    end
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    // quiet idle period, also lets tile resets release
    idle(8);
    if (rsp_count_o !== 16'd0) begin
      report_failure($sformatf("Mismatch rsp_count_o: got %h expected %h", rsp_count_o, 16'd0));
    end

    // store then load, plus an unwritten word
    send_cmd(OP_STORE, 1, 3, 32'hdead_beef);
    send_cmd(OP_LOAD, 1, 3, '0);
    send_cmd(OP_LOAD, 2, 5, '0);
    drain();

    // fetch-and-add chain
    send_cmd(OP_ADD, 3, 7, 32'h0000_0005);
    send_cmd(OP_ADD, 3, 7, 32'h0000_000a);
    send_cmd(OP_ADD, 3, 7, 32'h0000_0100);
    send_cmd(OP_LOAD, 3, 7, '0);
    drain();

    // same address, independent tiles
    for (int t = 0; t < num_tiles_lp; t++) begin
      send_cmd(OP_STORE, t, 2, 32'h1111_0000 + 32'(t));
    end
    for (int t = 0; t < num_tiles_lp; t++) begin
      send_cmd(OP_LOAD, t, 2, '0);
    end
    drain();

    // out-of-range commands are dropped
    send_cmd(OP_STORE, num_tiles_lp, 2, 32'hbad0_0001);
    idle(1);
    send_cmd(OP_ADD, 7, 2, 32'hbad0_0002);
    drain();

    // random stream, mostly back to back
    for (int n = 0; n < 80; n++) begin
      r_op = int'(take_bits(2)) % 3;
      send_cmd(op_e'(r_op), int'(take_bits(3)), int'(take_bits(4)), take_bits(32));
      if (take_bits(2) == 32'd0) begin
        idle(int'(take_bits(2)) + 1);
      end
    end
    drain();

    // read back everything so stray writes show up
    for (int t = 0; t < num_tiles_lp; t++) begin
      for (int a = 0; a < words_lp; a++) begin
        send_cmd(OP_LOAD, t, a, '0);
      end
    end
    drain();
    idle(num_tiles_lp + 4);

    if (rsp_count_o !== 16'(legal_cnt)) begin
      report_failure($sformatf("Mismatch rsp_count_o: got %h expected %h",
                               rsp_count_o, 16'(legal_cnt)));
    end
    if (mesh_row_top_inst.mesh_row_assert_inst.fail_count != 0) begin
      $display("** FAIL **");
      $fatal(1, "assertion failures recorded");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire
